//--- hw/eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// 2-kbyte part, three block bits ride in the control byte
`define EE_ADDR_W       11
`define EE_DEV_CODE     4'b1010
`define EE_FIFO_DEPTH   4       // power of two
`define EE_SCL_DIV      4       // CLK cycles per quarter SCL bit

// command register fields
`define EE_CMD_DATA_LSB 0
`define EE_CMD_ADDR_LSB 8
`define EE_CMD_OP_BIT   31      // 1 = read

`define EE_REG_CMD      32'h0000_0000
`define EE_REG_STATUS   32'h0000_0004
`define EE_REG_RDATA    32'h0000_0008

`define EE_ST_BUSY      0
`define EE_ST_FULL      1
`define EE_ST_RVALID    2
`define EE_ST_NACK      3

`endif

//--- hw/eeprom_pkg.sv
package eeprom_pkg;

    typedef enum logic {
        EE_OP_WRITE = 1'b0,
        EE_OP_READ  = 1'b1
    } ee_op_e;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        WDATA,
        RSTART,
        CTRL_R,
        RDATA,
        MACK,
        STOP
    } ee_state_e;

    // quarter periods of one SCL bit
    typedef enum logic [1:0] {PH_0, PH_1, PH_2, PH_3} ee_phase_e;

    typedef enum logic [1:0] {
        EE_RESP_OKAY   = 2'b00,
        EE_RESP_SLVERR = 2'b10
    } ee_resp_e;

endpackage

//--- hw/eeprom_axil_regs.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_axil_regs import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  logic [31:0]           aw_addr,
    input  logic                  w_valid,
    output logic                  w_ready,
    input  logic [31:0]           w_data,
    input  logic [3:0]            w_strb,     // full word writes only
    output logic                  b_valid,
    input  logic                  b_ready,
    output ee_resp_e              b_resp,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  logic [31:0]           ar_addr,
    output logic                  r_valid,
    input  logic                  r_ready,
    output logic [31:0]           r_data,
    output ee_resp_e              r_resp,
    output logic                  push_valid,
    input  logic                  push_ready,
    output ee_op_e                push_op,
    output logic [`EE_ADDR_W-1:0] push_addr,
    output logic [7:0]            push_data,
    input  logic                  done,
    input  logic                  rd_done,
    input  logic [7:0]            rd_byte,
    input  logic                  nack,
    input  logic                  busy,
    input  logic                  fifo_empty
);

    logic        wr_acc;
    logic        wr_cmd;
    logic        rd_acc;
    logic [7:0]  rdata_q;
    logic        rvalid_q;
    logic        nack_q;
    logic [31:0] status;

    // AW and W accepted together, one response outstanding at most
    assign wr_acc   = aw_valid && w_valid && !b_valid;
    assign aw_ready = wr_acc;
    assign w_ready  = wr_acc;
    assign wr_cmd   = (aw_addr == `EE_REG_CMD);

    assign push_valid = wr_acc && wr_cmd && push_ready;
    assign push_op    = w_data[`EE_CMD_OP_BIT] ? EE_OP_READ : EE_OP_WRITE;
    assign push_addr  = w_data[`EE_CMD_ADDR_LSB +: `EE_ADDR_W];
    assign push_data  = w_data[`EE_CMD_DATA_LSB +: 8];

    assign ar_ready = !r_valid;
    assign rd_acc   = ar_valid && !r_valid;

    always_comb
    begin
        status = '0;
        status[`EE_ST_BUSY]   = busy || !fifo_empty;
        status[`EE_ST_FULL]   = !push_ready;
        status[`EE_ST_RVALID] = rvalid_q;
        status[`EE_ST_NACK]   = nack_q;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            b_valid <= 1'b0;
        end
        else if (wr_acc)
        begin
            b_valid <= 1'b1;
            b_resp  <= (wr_cmd && push_ready) ? EE_RESP_OKAY : EE_RESP_SLVERR; // full queue refuses
        end
        else if (b_ready)
        begin
            b_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            r_valid  <= 1'b0;
            rvalid_q <= 1'b0;
            nack_q   <= 1'b0;
        end
        else
        begin
            if (rd_acc)
            begin
                r_valid <= 1'b1;
                r_resp  <= EE_RESP_OKAY;
                r_data  <= '0;
                case (ar_addr)
                    `EE_REG_CMD:    r_data <= '0;    // write only
                    `EE_REG_STATUS:
                    begin
                        r_data <= status;
                        nack_q <= 1'b0;              // read clears
                    end
                    `EE_REG_RDATA:
                    begin
                        r_data   <= {24'b0, rdata_q};
                        rvalid_q <= 1'b0;
                    end
                    default:        r_resp <= EE_RESP_SLVERR;
                endcase
            end
            else if (r_ready)
            begin
                r_valid <= 1'b0;
            end

            // engine events win over a same cycle clear
            if (rd_done && !nack)
            begin
                rvalid_q <= 1'b1;
                rdata_q  <= rd_byte;
            end
            if ((done || rd_done) && nack)
                nack_q <= 1'b1;
        end
    end

endmodule

//--- hw/eeprom_cmd_fifo.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_cmd_fifo import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  push_valid,
    output logic                  push_ready,
    input  ee_op_e                push_op,
    input  logic [`EE_ADDR_W-1:0] push_addr,
    input  logic [7:0]            push_data,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    output ee_op_e                cmd_op,
    output logic [`EE_ADDR_W-1:0] cmd_addr,
    output logic [7:0]            cmd_data,
    output logic                  empty
);

    localparam int PTR_W = $clog2(`EE_FIFO_DEPTH);

    ee_op_e                op_mem   [`EE_FIFO_DEPTH];
    logic [`EE_ADDR_W-1:0] addr_mem [`EE_FIFO_DEPTH];
    logic [7:0]            data_mem [`EE_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;
    logic                  do_push;
    logic                  do_pop;

    assign do_pop     = cmd_valid && cmd_ready;
    assign push_ready = (count != (PTR_W+1)'(`EE_FIFO_DEPTH)) || do_pop; // pop frees a slot
    assign do_push    = push_valid && push_ready;
    assign cmd_valid  = (count != '0);
    assign empty      = (count == '0);

    assign cmd_op   = op_mem[rd_ptr];
    assign cmd_addr = addr_mem[rd_ptr];
    assign cmd_data = data_mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (do_push)
        begin
            op_mem[wr_ptr]   <= push_op;
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;     // wraps, depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/eeprom_i2c_engine.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_i2c_engine import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  ee_op_e                cmd_op,
    input  logic [`EE_ADDR_W-1:0] cmd_addr,
    input  logic [7:0]            cmd_data,
    output logic                  done,
    output logic                  rd_done,
    output logic [7:0]            rd_byte,
    output logic                  nack,
    output logic                  busy,
    output logic                  scl,
    output logic                  sda_oe,
    input  logic                  sda_in
);

    localparam int DIV_W = $clog2(`EE_SCL_DIV);

    ee_state_e             state;
    ee_phase_e             phase;
    logic [DIV_W-1:0]      div_cnt;
    logic [3:0]            bit_cnt;
    logic [7:0]            shreg;
    ee_op_e                op;
    logic [`EE_ADDR_W-1:0] addr;
    logic [7:0]            data;
    logic                  tick;
    logic                  bit_end;
    logic                  scl_d;
    logic                  sda_oe_d;

    assign cmd_ready = (state == IDLE);
    assign busy      = (state != IDLE) || done || rd_done;   // through the done cycle
    assign tick      = (div_cnt == DIV_W'(`EE_SCL_DIV - 1));
    assign bit_end   = tick && (phase == PH_3);

    // SCL low in PH_0/PH_1, high in PH_2/PH_3.
    // SDA moves in PH_1, a quarter after the falling edge, and holds in PH_0.
    always_comb
    begin
        scl_d    = (phase == PH_2) || (phase == PH_3);
        sda_oe_d = sda_oe;
        case (state)
            IDLE:
            begin
                scl_d    = 1'b1;
                sda_oe_d = 1'b0;
            end
            START, RSTART:
            begin
                if (phase == PH_1 || phase == PH_2)
                    sda_oe_d = 1'b0;
                else if (phase == PH_3)
                    sda_oe_d = 1'b1;     // falls with SCL high
            end
            STOP:
            begin
                if (phase == PH_1 || phase == PH_2)
                    sda_oe_d = 1'b1;
                else if (phase == PH_3)
                    sda_oe_d = 1'b0;     // rises with SCL high
            end
            RDATA, MACK:
            begin
                if (phase != PH_0)
                    sda_oe_d = 1'b0;     // slave drives, or master nack
            end
            default:
            begin
                if (phase != PH_0)
                    sda_oe_d = (bit_cnt < 4'd8) ? !shreg[7] : 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= IDLE;
            phase   <= PH_0;
            div_cnt <= '0;
            bit_cnt <= '0;
            nack    <= 1'b0;
            done    <= 1'b0;
            rd_done <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else
        begin
            done    <= 1'b0;
            rd_done <= 1'b0;
            scl     <= scl_d;
            sda_oe  <= sda_oe_d;
            if (state == IDLE)
            begin
                div_cnt <= '0;
                phase   <= PH_0;
                if (cmd_valid)
                begin
                    op      <= cmd_op;
                    addr    <= cmd_addr;
                    data    <= cmd_data;
                    nack    <= 1'b0;
                    bit_cnt <= '0;
                    state   <= START;
                end
            end
            else
            begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick)
                    phase <= ee_phase_e'(phase + 2'd1);
                if (bit_end)
                begin
                    case (state)
                        START:
                        begin
                            shreg <= {`EE_DEV_CODE, addr[`EE_ADDR_W-1:8], 1'b0};
                            state <= CTRL_W;
                        end
                        CTRL_W, ADDR, WDATA, CTRL_R:
                        begin
                            if (bit_cnt != 4'd8)
                            begin
                                shreg   <= {shreg[6:0], 1'b0};
                                bit_cnt <= bit_cnt + 4'd1;
                            end
                            else
                            begin
                                bit_cnt <= '0;
                                if (sda_in)
                                begin
                                    nack  <= 1'b1;       // no ack, abort
                                    state <= STOP;
                                end
                                else
                                begin
                                    case (state)
                                        CTRL_W:
                                        begin
                                            shreg <= addr[7:0];
                                            state <= ADDR;
                                        end
                                        ADDR:
                                        begin
                                            shreg <= data;
                                            state <= (op == EE_OP_READ) ? RSTART : WDATA;
                                        end
                                        CTRL_R:  state <= RDATA;
                                        default: state <= STOP;
                                    endcase
                                end
                            end
                        end
                        RSTART:
                        begin
                            shreg <= {`EE_DEV_CODE, addr[`EE_ADDR_W-1:8], 1'b1};
                            state <= CTRL_R;
                        end
                        RDATA:
                        begin
                            shreg <= {shreg[6:0], sda_in};
                            if (bit_cnt == 4'd7)
                            begin
                                rd_byte <= {shreg[6:0], sda_in};
                                bit_cnt <= '0;
                                state   <= MACK;
                            end
                            else
                            begin
                                bit_cnt <= bit_cnt + 4'd1;
                            end
                        end
                        MACK:    state <= STOP;
                        STOP:
                        begin
                            state   <= IDLE;
                            rd_done <= (op == EE_OP_READ);
                            done    <= (op == EE_OP_WRITE);
                        end
                        default: state <= IDLE;
                    endcase
                end
            end
        end
    end

endmodule

//--- hw/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_ctrl_top import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  logic [31:0] aw_addr,
    input  logic        w_valid,
    output logic        w_ready,
    input  logic [31:0] w_data,
    input  logic [3:0]  w_strb,
    output logic        b_valid,
    input  logic        b_ready,
    output ee_resp_e    b_resp,
    input  logic        ar_valid,
    output logic        ar_ready,
    input  logic [31:0] ar_addr,
    output logic        r_valid,
    input  logic        r_ready,
    output logic [31:0] r_data,
    output ee_resp_e    r_resp,
    output logic        scl,
    output logic        sda_oe,
    input  logic        sda_in
);

    logic                  push_valid;
    logic                  push_ready;
    ee_op_e                push_op;
    logic [`EE_ADDR_W-1:0] push_addr;
    logic [7:0]            push_data;
    logic                  fifo_empty;
    logic                  cmd_valid;
    logic                  cmd_ready;
    ee_op_e                cmd_op;
    logic [`EE_ADDR_W-1:0] cmd_addr;
    logic [7:0]            cmd_data;
    logic                  done;
    logic                  rd_done;
    logic [7:0]            rd_byte;
    logic                  nack;
    logic                  busy;

    eeprom_axil_regs u_regs (
        .CLK(CLK), .RESET(RESET),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_strb(w_strb),
        .b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data), .r_resp(r_resp),
        .push_valid(push_valid), .push_ready(push_ready), .push_op(push_op),
        .push_addr(push_addr), .push_data(push_data),
        .done(done), .rd_done(rd_done), .rd_byte(rd_byte), .nack(nack),
        .busy(busy), .fifo_empty(fifo_empty)
    );

    eeprom_cmd_fifo u_fifo (
        .CLK(CLK), .RESET(RESET),
        .push_valid(push_valid), .push_ready(push_ready), .push_op(push_op),
        .push_addr(push_addr), .push_data(push_data),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
        .cmd_addr(cmd_addr), .cmd_data(cmd_data), .empty(fifo_empty)
    );

    eeprom_i2c_engine u_engine (
        .CLK(CLK), .RESET(RESET),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
        .cmd_addr(cmd_addr), .cmd_data(cmd_data),
        .done(done), .rd_done(rd_done), .rd_byte(rd_byte), .nack(nack), .busy(busy),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
    );

endmodule

//--- dv/eeprom_slave_model.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_slave_model
(
    input  logic scl,
    input  logic sda,
    output logic sda_pull      // high pulls SDA low
);

    typedef enum {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_SEND} mode_e;

    logic [7:0]            mem [2**`EE_ADDR_W];
    logic [`EE_ADDR_W-1:0] ptr;
    logic [7:0]            shreg;
    mode_e                 mode;
    mode_e                 next_mode;
    int                    bit_cnt;

    initial
    begin
        for (int i = 0; i < 2**`EE_ADDR_W; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'ha5;
        ptr       = '0;
        mode      = M_IDLE;
        next_mode = M_IDLE;
        bit_cnt   = 0;
        sda_pull  = 1'b0;
    end

    // decide ack after eight received bits
    task automatic take_byte();
        case (mode)
            M_CTRL:
            begin
                if (shreg[7:4] == `EE_DEV_CODE && shreg[3:1] != 3'd7)
                begin
                    ptr[`EE_ADDR_W-1:8] = shreg[3:1];
                    next_mode = shreg[0] ? M_SEND : M_ADDR;
                    sda_pull  = 1'b1;
                end
                else
                    next_mode = M_IDLE;     // block 7 stays silent
            end
            M_ADDR:
            begin
                ptr[7:0]  = shreg;
                next_mode = M_WDATA;
                sda_pull  = 1'b1;
            end
            default:
            begin
                mem[ptr]  = shreg;          // no internal write cycle
                next_mode = M_IDLE;
                sda_pull  = 1'b1;
            end
        endcase
    endtask

    // start and stop, SDA moving while SCL high
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode     = M_CTRL;
            bit_cnt  = 0;
            sda_pull = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode     = M_IDLE;
            bit_cnt  = 0;
            sda_pull = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (mode != M_IDLE)
        begin
            if (bit_cnt < 8 && mode != M_SEND)
                shreg = {shreg[6:0], sda};
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl)
    begin
        if (mode != M_IDLE)
        begin
            if (bit_cnt == 9)
            begin
                bit_cnt = 0;
                mode    = next_mode;
            end
            if (bit_cnt == 8)
            begin
                sda_pull = 1'b0;
                if (mode != M_SEND)
                    take_byte();
                else
                    next_mode = M_IDLE;     // master nacks, one byte only
            end
            else
                sda_pull = (mode == M_SEND) ? !mem[ptr][7 - bit_cnt] : 1'b0;
        end
    end

endmodule

//--- dv/eeprom_ctrl_props.sv
`timescale 1ns/1ps

module eeprom_ctrl_props import eeprom_pkg::*;
(
    input logic        CLK,
    input logic        RESET,
    input logic        b_valid,
    input logic        b_ready,
    input ee_resp_e    b_resp,
    input logic        r_valid,
    input logic        r_ready,
    input logic [31:0] r_data,
    input logic        busy,
    input logic        scl,
    input logic        sda_oe,
    input logic        cmd_valid,
    input logic        cmd_ready,
    input ee_state_e   state
);

    int fail_count = 0;

    b_hold: assert property (@(posedge CLK) disable iff (RESET)
        b_valid && !b_ready |=> b_valid && $stable(b_resp))
    else
    begin
        fail_count++;
        $error("b_valid or b_resp changed before b_ready");
    end

    r_hold: assert property (@(posedge CLK) disable iff (RESET)
        r_valid && !r_ready |=> r_valid && $stable(r_data))
    else
    begin
        fail_count++;
        $error("r_valid or r_data changed before r_ready");
    end

    // bus released whenever the engine rests
    bus_idle: assert property (@(posedge CLK) disable iff (RESET)
        !busy |-> scl && !sda_oe)
    else
    begin
        fail_count++;
        $error("SCL low or SDA driven while the engine is idle");
    end

    // a taken command moves the engine out of IDLE at once
    ready_start: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid && cmd_ready |=> state == START && !cmd_ready)
    else
    begin
        fail_count++;
        $error("engine did not leave IDLE after taking a command");
    end

endmodule

//--- dv/eeprom_ctrl_tb.sv
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_ctrl_tb import eeprom_pkg::*; ();

    localparam int N_RAND   = 8;
    localparam int N_CMDS   = 4 * N_RAND + 2;
    localparam int MEM_SIZE = 2 ** `EE_ADDR_W;
    localparam int LIMIT    = N_CMDS * 45 * 4 * `EE_SCL_DIV + 2000;

    localparam logic [31:0] ST_BUSY   = 32'h1 << `EE_ST_BUSY;
    localparam logic [31:0] ST_FULL   = 32'h1 << `EE_ST_FULL;
    localparam logic [31:0] ST_RVALID = 32'h1 << `EE_ST_RVALID;
    localparam logic [31:0] ST_NACK   = 32'h1 << `EE_ST_NACK;

    logic        CLK;
    logic        RESET;
    logic        aw_valid;
    logic        aw_ready;
    logic [31:0] aw_addr;
    logic        w_valid;
    logic        w_ready;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        b_valid;
    logic        b_ready;
    ee_resp_e    b_resp;
    logic        ar_valid;
    logic        ar_ready;
    logic [31:0] ar_addr;
    logic        r_valid;
    logic        r_ready;
    logic [31:0] r_data;
    ee_resp_e    r_resp;
    logic        scl;
    logic        sda_oe;
    logic        sda_pull;
    tri1         sda;

    integer      seed;
    int          errors;
    logic [7:0]  shadow [MEM_SIZE];
    logic [7:0]  got_q [$];
    logic [7:0]  exp_q [$];

    assign sda = sda_oe ? 1'b0 : 1'bz;
    assign sda = sda_pull ? 1'b0 : 1'bz;

    eeprom_ctrl_top dut (
        .CLK(CLK), .RESET(RESET),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_strb(w_strb),
        .b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data), .r_resp(r_resp),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda)
    );

    eeprom_slave_model u_slave (.scl(scl), .sda(sda), .sda_pull(sda_pull));

    bind eeprom_ctrl_top eeprom_ctrl_props u_props (
        .CLK(CLK), .RESET(RESET),
        .b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp),
        .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data),
        .busy(busy), .scl(scl), .sda_oe(sda_oe),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .state(u_engine.state)
    );

    always #4 CLK = ~CLK;

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input ee_resp_e got, input ee_resp_e exp);
        if (got !== exp)
            report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_status(input string name, input logic [31:0] got,
                                input logic [31:0] exp, input logic [31:0] mask);
        if ((got & mask) !== (exp & mask))
            report_failure($sformatf("Fail %s: got %h expected %h mask %h",
                                     name, got, exp, mask));
    endtask

    function automatic logic [7:0] fill_pattern(input int a);
        return 8'(a) ^ 8'(a >> 3) ^ 8'ha5;
    endfunction

    function automatic logic [7:0] ee_expect_read(input logic [`EE_ADDR_W-1:0] addr);
        return shadow[addr];
    endfunction

    task automatic pick_addr(output logic [`EE_ADDR_W-1:0] addr);
        logic [2:0] blk;
        blk  = 3'($unsigned($random(seed)) % 7);   // blocks 0 to 6
        addr = {blk, 8'($random(seed))};
    endtask

    // no response is outstanding here, so AW and W go in at the first edge
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output ee_resp_e resp);
        int hold;
        @(negedge CLK);
        aw_valid = 1'b1;
        aw_addr  = addr;
        w_valid  = 1'b1;
        w_data   = data;
        @(posedge CLK);
        check_flag("aw_ready", aw_ready, 1'b1);
        check_flag("w_ready", w_ready, 1'b1);
        @(negedge CLK);
        check_flag("b_valid", b_valid, 1'b1);     // one cycle after the accept
        check_flag("aw_ready", aw_ready, 1'b0);   // response pending
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        resp     = b_resp;
        hold     = $unsigned($random(seed)) % 3;
        repeat (hold) @(negedge CLK);
        b_ready = 1'b1;
        @(negedge CLK);
        b_ready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output ee_resp_e resp);
        int hold;
        @(negedge CLK);
        ar_valid = 1'b1;
        ar_addr  = addr;
        @(posedge CLK);
        check_flag("ar_ready", ar_ready, 1'b1);
        @(negedge CLK);
        check_flag("r_valid", r_valid, 1'b1);
        check_flag("ar_ready", ar_ready, 1'b0);
        ar_valid = 1'b0;
        data     = r_data;
        resp     = r_resp;
        hold     = $unsigned($random(seed)) % 3;
        repeat (hold) @(negedge CLK);
        r_ready = 1'b1;
        @(negedge CLK);
        r_ready = 1'b0;
    endtask

    task automatic send_cmd(input ee_op_e op, input logic [`EE_ADDR_W-1:0] addr,
                            input logic [7:0] data, output ee_resp_e resp);
        logic [31:0] word;
        word = '0;
        word[`EE_CMD_OP_BIT] = (op == EE_OP_READ);
        word[`EE_CMD_ADDR_LSB +: `EE_ADDR_W] = addr;
        word[`EE_CMD_DATA_LSB +: 8] = data;
        axi_write(`EE_REG_CMD, word, resp);
        if (resp == EE_RESP_OKAY && op == EE_OP_WRITE && addr[`EE_ADDR_W-1:8] != 3'd7)
            shadow[addr] = data;
    endtask

    task automatic wait_idle(output logic [31:0] st);
        ee_resp_e resp;
        st = '1;
        while (st[`EE_ST_BUSY])
            axi_read(`EE_REG_STATUS, st, resp);
    endtask

    task automatic read_back(input logic [`EE_ADDR_W-1:0] addr);
        ee_resp_e    resp;
        logic [31:0] word;
        send_cmd(EE_OP_READ, addr, 8'h00, resp);
        check_resp("b_resp", resp, EE_RESP_OKAY);
        wait_idle(word);
        check_status("status", word, ST_RVALID, ST_RVALID | ST_NACK);
        axi_read(`EE_REG_RDATA, word, resp);
        check_resp("r_resp", resp, EE_RESP_OKAY);
        got_q.push_back(word[7:0]);
        exp_q.push_back(ee_expect_read(addr));
        axi_read(`EE_REG_STATUS, word, resp);
        check_status("status", word, 32'h0, ST_RVALID);   // cleared by the RDATA read
    endtask

    always @(posedge CLK)
    begin
        while (got_q.size() != 0)
            check_byte("rdata", got_q.pop_front(), exp_q.pop_front());
    end

    always @(negedge CLK)
    begin
        if (dut.u_props.fail_count != 0)
            report_failure("a bound assertion failed");
    end

    initial
    begin
        repeat (LIMIT) @(posedge CLK);
        report_failure($sformatf("watchdog expired after %0d cycles", LIMIT));
    end

    initial
    begin
        ee_resp_e              resp;
        ee_op_e                op;
        logic [31:0]           word;
        logic [`EE_ADDR_W-1:0] addrs [N_RAND];
        logic [`EE_ADDR_W-1:0] a;
        logic [`EE_ADDR_W-1:0] okay_addr [$];
        int                    refused;

        seed     = 32'h166e_ba01;
        errors   = 0;
        CLK      = 1'b0;
        RESET    = 1'b1;
        aw_valid = 1'b0;
        aw_addr  = '0;
        w_valid  = 1'b0;
        w_data   = '0;
        w_strb   = 4'hf;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar_addr  = '0;
        r_ready  = 1'b0;
        for (int i = 0; i < MEM_SIZE; i++)
            shadow[i] = fill_pattern(i);
        repeat (16) @(negedge CLK);
        RESET = 1'b0;

        for (int i = 0; i < N_RAND; i++)
        begin
            pick_addr(addrs[i]);
            send_cmd(EE_OP_WRITE, addrs[i], 8'($random(seed)), resp);
            check_resp("b_resp", resp, EE_RESP_OKAY);
            wait_idle(word);
        end
        for (int i = 0; i < N_RAND; i++)
            read_back(addrs[i]);

        // overrun the queue while the engine is busy
        refused = 0;
        for (int i = 0; i < N_RAND; i++)
        begin
            pick_addr(a);
            send_cmd(EE_OP_WRITE, a, 8'($random(seed)), resp);
            if (resp == EE_RESP_SLVERR)
                refused++;
            else
                okay_addr.push_back(a);
        end
        axi_read(`EE_REG_STATUS, word, resp);
        check_status("status", word, ST_BUSY | ST_FULL, ST_BUSY | ST_FULL);
        if (refused == 0)
            report_failure("no command was refused while the queue was full");
        wait_idle(word);
        foreach (okay_addr[i])
            read_back(okay_addr[i]);

        // block 7, read then write
        for (int k = 0; k < 2; k++)
        begin
            op = k ? EE_OP_WRITE : EE_OP_READ;
            pick_addr(a);
            a[`EE_ADDR_W-1:8] = 3'd7;
            send_cmd(op, a, 8'($random(seed)), resp);
            check_resp("b_resp", resp, EE_RESP_OKAY);
            wait_idle(word);
            check_status("status", word, ST_NACK, ST_NACK | ST_RVALID);
            axi_read(`EE_REG_STATUS, word, resp);
            check_status("status", word, 32'h0, ST_NACK | ST_RVALID);
        end

        axi_write(32'h0000_000c, 32'h1234_5678, resp);
        check_resp("b_resp", resp, EE_RESP_SLVERR);
        axi_write(`EE_REG_STATUS, 32'h0000_00ff, resp);
        check_resp("b_resp", resp, EE_RESP_SLVERR);
        axi_read(32'h0000_000c, word, resp);
        check_resp("r_resp", resp, EE_RESP_SLVERR);
        check_status("r_data", word, 32'h0, 32'hffff_ffff);
        axi_read(32'h0000_0100, word, resp);
        check_resp("r_resp", resp, EE_RESP_SLVERR);
        check_status("r_data", word, 32'h0, 32'hffff_ffff);
        axi_read(`EE_REG_STATUS, word, resp);
        check_status("status", word, 32'h0, ST_BUSY);   // nothing was queued

        wait_idle(word);
        for (int i = 0; i < MEM_SIZE; i++)
            check_byte($sformatf("mem[%0h]", i), u_slave.mem[i], shadow[i]);
        @(posedge CLK);
        @(negedge CLK);
        if (got_q.size() != 0)
            report_failure("read results were left without a compare");

        if (errors == 0 && dut.u_props.fail_count == 0)
        begin
            $display("test passed");
            $finish;
        end
        else
            report_failure("errors were recorded during the run");
    end

endmodule

//--- all.f
+incdir+hw
hw/eeprom_pkg.sv
hw/eeprom_axil_regs.sv
hw/eeprom_cmd_fifo.sv
hw/eeprom_i2c_engine.sv
hw/eeprom_ctrl_top.sv
dv/eeprom_slave_model.sv
dv/eeprom_ctrl_props.sv
dv/eeprom_ctrl_tb.sv

//--- Bender.yml
package:
  name: eeprom_ctrl

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/eeprom_pkg.sv
      - hw/eeprom_axil_regs.sv
      - hw/eeprom_cmd_fifo.sv
      - hw/eeprom_i2c_engine.sv
      - hw/eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/eeprom_slave_model.sv
      - dv/eeprom_ctrl_props.sv
      - dv/eeprom_ctrl_tb.sv
